// ==== gather_settings.svh ====
`ifndef GATHER_SETTINGS_SVH
`define GATHER_SETTINGS_SVH

// --------------------
// Lane configuration
// --------------------

// Number of parallel gather lanes
`define NUM_LANES 2

// Depth of each lane's output queue
`define PREFETCH_DEPTH 4

// --------------------
// Buffer memory geometry
// --------------------

// Bytes in one data word
`define WORD_BYTES 8

// Words in one buffer
`define BUF_WORDS 4

// Buffers in each memory replica
`define NUM_BUFS 16

`endif

// ==== hdl/gather_types_pkg.sv ====
`include "gather_settings.svh"

package gather_types_pkg;

    // --------------------
    // Payload
    // --------------------

    typedef logic [`WORD_BYTES*8-1:0] word_t;

    // Empty bytes in the last word of a packet
    typedef logic [$clog2(`WORD_BYTES)-1:0] mty_t;

    typedef logic [7:0] meta_t;

    // --------------------
    // Buffer addressing
    // --------------------

    typedef logic [$clog2(`NUM_BUFS)-1:0] buf_ptr_t;

    // Buffer index in the upper bits, word index in the lower bits
    typedef logic [$clog2(`NUM_BUFS*`BUF_WORDS)-1:0] mem_addr_t;

    // Valid bytes in one buffer from 1 up to a full buffer
    typedef logic [$clog2(`BUF_WORDS*`WORD_BYTES+1)-1:0] buf_size_t;

    // One entry of the link table
    typedef struct packed {
        buf_ptr_t  nxt;
        logic      last;
        buf_size_t size;
    } link_entry_t;

endpackage

// ==== hdl/gather_ctrl_pkg.sv ====
`include "gather_settings.svh"

package gather_ctrl_pkg;

    // --------------------
    // FSM states
    // --------------------

    typedef enum logic [1:0] {
        IDLE,
        READ,
        DRAIN
    } lane_state_e;

    typedef enum logic {
        SEARCH,
        LOCK
    } arb_state_e;

    // --------------------
    // Round-robin helpers
    // --------------------

    // First requesting lane at or after start; start itself when nobody requests
    function automatic int rr_pick(input logic [`NUM_LANES-1:0] req, input int start);
        int idx;
        rr_pick = start;
        for (int k = `NUM_LANES - 1; k >= 0; k--) begin
            idx = (start + k) % `NUM_LANES;
            if (req[idx]) begin
                rr_pick = idx;
            end
        end
    endfunction

    function automatic int rr_after(input int idx);
        rr_after = (idx + 1) % `NUM_LANES;
    endfunction

endpackage

// ==== hdl/gather_intf.sv ====
`timescale 1ns/1ps

// Descriptor handoff from the dispatcher to one lane
interface desc_intf ();
    logic                       vld;
    logic                       rdy;
    gather_types_pkg::buf_ptr_t ptr;
    gather_types_pkg::meta_t    meta;

    modport dispatch (
        output vld,
        output ptr,
        output meta,
        input  rdy
    );

    modport lane (
        input  vld,
        input  ptr,
        input  meta,
        output rdy
    );
endinterface

// Packet beats from one lane to the arbiter
interface pkt_intf ();
    logic                    vld;
    logic                    rdy;
    gather_types_pkg::word_t data;
    logic                    eop;
    gather_types_pkg::mty_t  mty;
    gather_types_pkg::meta_t meta;

    modport src (
        output vld,
        output data,
        output eop,
        output mty,
        output meta,
        input  rdy
    );

    modport sink (
        input  vld,
        input  data,
        input  eop,
        input  mty,
        input  meta,
        output rdy
    );
endinterface

// ==== hdl/desc_dispatch.sv ====
`timescale 1ns/1ps
`include "gather_settings.svh"

module desc_dispatch (
    input  logic                       clk,
    input  logic                       srst,
    input  logic                       desc_vld,
    output logic                       desc_rdy,
    input  gather_types_pkg::buf_ptr_t desc_ptr,
    input  gather_types_pkg::meta_t    desc_meta,
    desc_intf.dispatch                 lanes [`NUM_LANES]
);
    localparam int IDX_W = (`NUM_LANES > 1) ? $clog2(`NUM_LANES) : 1;

    logic [`NUM_LANES-1:0] lane_rdy;
    logic [IDX_W-1:0]      rr_ptr;
    logic [IDX_W-1:0]      sel;

    // --------------------
    // Lane selection
    // --------------------

    // Nearest idle lane from the pointer
    assign sel      = IDX_W'(gather_ctrl_pkg::rr_pick(lane_rdy, int'(rr_ptr)));
    assign desc_rdy = |lane_rdy;

    always_ff @(posedge clk) begin
        if (srst) begin
            rr_ptr <= '0;
        end else if (desc_vld && desc_rdy) begin
            rr_ptr <= IDX_W'(gather_ctrl_pkg::rr_after(int'(sel)));
        end
    end

    // --------------------
    // Per-lane steering
    // --------------------

    generate
        for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
            assign lane_rdy[i]    = lanes[i].rdy;
            // Only the chosen lane sees a valid descriptor
            assign lanes[i].vld  = desc_vld && desc_rdy && (sel == IDX_W'(i));
            assign lanes[i].ptr  = desc_ptr;
            assign lanes[i].meta = desc_meta;
        end
    endgenerate

endmodule

// ==== hdl/gather_lane.sv ====
`timescale 1ns/1ps
`include "gather_settings.svh"

module gather_lane (
    input  logic                          clk,
    input  logic                          srst,
    input  logic                          mem_wr,
    input  gather_types_pkg::mem_addr_t   mem_addr,
    input  gather_types_pkg::word_t       mem_data,
    input  logic                          link_wr,
    input  gather_types_pkg::buf_ptr_t    link_ptr,
    input  gather_types_pkg::link_entry_t link_entry,
    desc_intf.lane                        desc,
    pkt_intf.src                          pkt
);
    localparam int WIDX_W = $clog2(`BUF_WORDS);
    localparam int QPTR_W = $clog2(`PREFETCH_DEPTH);
    localparam int QCNT_W = $clog2(`PREFETCH_DEPTH + 1);

    typedef struct packed {
        logic                    eop;
        gather_types_pkg::mty_t  mty;
        gather_types_pkg::meta_t meta;
    } rd_ctxt_t;

    typedef struct packed {
        gather_types_pkg::word_t data;
        rd_ctxt_t                ctxt;
    } q_entry_t;

    gather_types_pkg::word_t       mem [`NUM_BUFS*`BUF_WORDS];
    gather_types_pkg::link_entry_t link_tbl [`NUM_BUFS];

    gather_ctrl_pkg::lane_state_e  state;
    gather_ctrl_pkg::lane_state_e  nxt_state;
    logic                          acc_rdy;
    logic                          desc_xfer;

    gather_types_pkg::buf_ptr_t    cur_ptr;
    logic [WIDX_W-1:0]             word_idx;
    gather_types_pkg::meta_t       cur_meta;
    gather_types_pkg::link_entry_t cur_link;
    logic [WIDX_W-1:0]             end_idx;
    logic                          end_of_buf;
    gather_types_pkg::mty_t        size_rem;

    logic                          rd_issue;
    gather_types_pkg::mem_addr_t   rd_addr;
    rd_ctxt_t                      rd_ctxt;
    gather_types_pkg::word_t       rd_data_q;
    rd_ctxt_t                      rd_ctxt_q;
    logic                          rd_vld_q;

    q_entry_t                      q_mem [`PREFETCH_DEPTH];
    q_entry_t                      q_in;
    q_entry_t                      q_head;
    logic [QPTR_W-1:0]             wr_ptr;
    logic [QPTR_W-1:0]             rd_ptr;
    logic [QCNT_W-1:0]             q_cnt;
    logic [QCNT_W-1:0]             credit;
    logic                          pop;

    // --------------------
    // Memory replicas
    // --------------------

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[mem_addr] <= mem_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_issue) begin
            rd_data_q <= mem[rd_addr];
            rd_ctxt_q <= rd_ctxt;
        end
    end

    always_ff @(posedge clk) begin
        if (link_wr) begin
            link_tbl[link_ptr] <= link_entry;
        end
    end

    // --------------------
    // Buffer walk
    // --------------------

    assign desc.rdy  = acc_rdy;
    assign desc_xfer = desc.vld && desc.rdy;

    assign cur_link   = link_tbl[cur_ptr];
    // Partial last buffer ends early
    assign end_idx    = cur_link.last ?
                        WIDX_W'((cur_link.size - 1'b1) / `WORD_BYTES) :
                        WIDX_W'(`BUF_WORDS - 1);
    assign end_of_buf = (word_idx == end_idx);
    assign size_rem   = gather_types_pkg::mty_t'(cur_link.size % `WORD_BYTES);

    // Issue only while every read in flight has a queue slot
    assign rd_issue = (state == gather_ctrl_pkg::READ) && (credit != '0);
    assign rd_addr  = {cur_ptr, word_idx};

    always_comb begin
        rd_ctxt.eop  = cur_link.last && end_of_buf;
        rd_ctxt.mty  = '0;
        rd_ctxt.meta = cur_meta;
        if (rd_ctxt.eop && size_rem != '0) begin
            rd_ctxt.mty = gather_types_pkg::mty_t'(`WORD_BYTES - size_rem);
        end
    end

    always_comb begin
        nxt_state = state;
        case (state)
            gather_ctrl_pkg::IDLE: begin
                if (desc_xfer) nxt_state = gather_ctrl_pkg::READ;
            end
            gather_ctrl_pkg::READ: begin
                if (rd_issue && rd_ctxt.eop) nxt_state = gather_ctrl_pkg::DRAIN;
            end
            // Last read lands in the queue here
            gather_ctrl_pkg::DRAIN: nxt_state = gather_ctrl_pkg::IDLE;
            default: nxt_state = gather_ctrl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            state    <= gather_ctrl_pkg::IDLE;
            acc_rdy  <= 1'b0;
            rd_vld_q <= 1'b0;
        end else begin
            state    <= nxt_state;
            acc_rdy  <= (nxt_state == gather_ctrl_pkg::IDLE);
            rd_vld_q <= rd_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (desc_xfer) begin
            cur_ptr  <= desc.ptr;
            cur_meta <= desc.meta;
            word_idx <= '0;
        end else if (rd_issue) begin
            if (end_of_buf) begin
                cur_ptr  <= cur_link.nxt;
                word_idx <= '0;
            end else begin
                word_idx <= word_idx + WIDX_W'(1);
            end
        end
    end

    // --------------------
    // Prefetch queue
    // --------------------

    assign q_in   = '{data: rd_data_q, ctxt: rd_ctxt_q};
    assign q_head = q_mem[rd_ptr];
    assign pop    = pkt.vld && pkt.rdy;

    always_ff @(posedge clk) begin
        if (rd_vld_q) begin
            q_mem[wr_ptr] <= q_in;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_cnt  <= '0;
            credit <= QCNT_W'(`PREFETCH_DEPTH);
        end else begin
            if (rd_vld_q) begin
                wr_ptr <= (wr_ptr == QPTR_W'(`PREFETCH_DEPTH - 1)) ? '0 : wr_ptr + QPTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == QPTR_W'(`PREFETCH_DEPTH - 1)) ? '0 : rd_ptr + QPTR_W'(1);
            end
            case ({rd_vld_q, pop})
                2'b10:   q_cnt <= q_cnt + QCNT_W'(1);
                2'b01:   q_cnt <= q_cnt - QCNT_W'(1);
                default: q_cnt <= q_cnt;
            endcase
            // A credit leaves with each read and returns with each pop
            case ({rd_issue, pop})
                2'b10:   credit <= credit - QCNT_W'(1);
                2'b01:   credit <= credit + QCNT_W'(1);
                default: credit <= credit;
            endcase
        end
    end

    assign pkt.vld  = (q_cnt != '0);
    assign pkt.data = q_head.data;
    assign pkt.eop  = q_head.ctxt.eop;
    assign pkt.mty  = q_head.ctxt.mty;
    assign pkt.meta = q_head.ctxt.meta;

endmodule

// ==== hdl/pkt_arbiter.sv ====
`timescale 1ns/1ps
`include "gather_settings.svh"

module pkt_arbiter (
    input  logic                    clk,
    input  logic                    srst,
    pkt_intf.sink                   lanes [`NUM_LANES],
    output logic                    pkt_vld,
    input  logic                    pkt_rdy,
    output gather_types_pkg::word_t pkt_data,
    output logic                    pkt_eop,
    output gather_types_pkg::mty_t  pkt_mty,
    output gather_types_pkg::meta_t pkt_meta
);
    localparam int IDX_W = (`NUM_LANES > 1) ? $clog2(`NUM_LANES) : 1;

    gather_ctrl_pkg::arb_state_e state;
    logic [IDX_W-1:0]            rr_ptr;
    logic [IDX_W-1:0]            grant;
    logic [IDX_W-1:0]            pick;
    logic [IDX_W-1:0]            cur;
    logic                        xfer_eop;

    logic [`NUM_LANES-1:0]       lane_vld;
    logic [`NUM_LANES-1:0]       lane_eop;
    gather_types_pkg::word_t     lane_data [`NUM_LANES];
    gather_types_pkg::mty_t      lane_mty [`NUM_LANES];
    gather_types_pkg::meta_t     lane_meta [`NUM_LANES];

    generate
        for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
            assign lane_vld[i]  = lanes[i].vld;
            assign lane_eop[i]  = lanes[i].eop;
            assign lane_data[i] = lanes[i].data;
            assign lane_mty[i]  = lanes[i].mty;
            assign lane_meta[i] = lanes[i].meta;
            assign lanes[i].rdy = pkt_rdy && (cur == IDX_W'(i));
        end
    endgenerate

    // --------------------
    // Output mux
    // --------------------

    assign pick = IDX_W'(gather_ctrl_pkg::rr_pick(lane_vld, int'(rr_ptr)));
    assign cur  = (state == gather_ctrl_pkg::LOCK) ? grant : pick;

    assign pkt_vld  = lane_vld[cur];
    assign pkt_data = lane_data[cur];
    assign pkt_eop  = lane_eop[cur];
    assign pkt_mty  = lane_mty[cur];
    assign pkt_meta = lane_meta[cur];

    assign xfer_eop = pkt_vld && pkt_rdy && pkt_eop;

    // --------------------
    // Grant FSM
    // --------------------

    always_ff @(posedge clk) begin
        if (srst) begin
            state  <= gather_ctrl_pkg::SEARCH;
            rr_ptr <= '0;
            grant  <= '0;
        end else begin
            case (state)
                gather_ctrl_pkg::SEARCH: begin
                    if (|lane_vld) begin
                        grant <= pick;
                        // Single-beat packet needs no lock
                        if (xfer_eop) begin
                            rr_ptr <= IDX_W'(gather_ctrl_pkg::rr_after(int'(pick)));
                        end else begin
                            state <= gather_ctrl_pkg::LOCK;
                        end
                    end
                end
                gather_ctrl_pkg::LOCK: begin
                    if (xfer_eop) begin
                        state  <= gather_ctrl_pkg::SEARCH;
                        rr_ptr <= IDX_W'(gather_ctrl_pkg::rr_after(int'(grant)));
                    end
                end
                default: state <= gather_ctrl_pkg::SEARCH;
            endcase
        end
    end

endmodule

// ==== hdl/gather_sys.sv ====
`timescale 1ns/1ps
`include "gather_settings.svh"

module gather_sys (
    input  logic                        clk,
    input  logic                        srst,

    input  logic                        mem_wr,
    input  gather_types_pkg::mem_addr_t mem_addr,
    input  gather_types_pkg::word_t     mem_data,

    input  logic                        link_wr,
    input  gather_types_pkg::buf_ptr_t  link_ptr,
    input  gather_types_pkg::buf_ptr_t  link_nxt,
    input  logic                        link_last,
    input  gather_types_pkg::buf_size_t link_size,

    input  logic                        desc_vld,
    output logic                        desc_rdy,
    input  gather_types_pkg::buf_ptr_t  desc_ptr,
    input  gather_types_pkg::meta_t     desc_meta,

    output logic                        pkt_vld,
    input  logic                        pkt_rdy,
    output gather_types_pkg::word_t     pkt_data,
    output logic                        pkt_eop,
    output gather_types_pkg::mty_t      pkt_mty,
    output gather_types_pkg::meta_t     pkt_meta
);
    gather_types_pkg::link_entry_t link_entry;

    desc_intf lane_desc [`NUM_LANES] ();
    pkt_intf  lane_pkt  [`NUM_LANES] ();

    assign link_entry.nxt  = link_nxt;
    assign link_entry.last = link_last;
    assign link_entry.size = link_size;

    desc_dispatch u_dispatch (
        .clk       (clk),
        .srst      (srst),
        .desc_vld  (desc_vld),
        .desc_rdy  (desc_rdy),
        .desc_ptr  (desc_ptr),
        .desc_meta (desc_meta),
        .lanes     (lane_desc)
    );

    // Every lane sees the same memory and link writes
    generate
        for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
            gather_lane u_lane (
                .clk        (clk),
                .srst       (srst),
                .mem_wr     (mem_wr),
                .mem_addr   (mem_addr),
                .mem_data   (mem_data),
                .link_wr    (link_wr),
                .link_ptr   (link_ptr),
                .link_entry (link_entry),
                .desc       (lane_desc[i]),
                .pkt        (lane_pkt[i])
            );
        end
    endgenerate

    pkt_arbiter u_arbiter (
        .clk      (clk),
        .srst     (srst),
        .lanes    (lane_pkt),
        .pkt_vld  (pkt_vld),
        .pkt_rdy  (pkt_rdy),
        .pkt_data (pkt_data),
        .pkt_eop  (pkt_eop),
        .pkt_mty  (pkt_mty),
        .pkt_meta (pkt_meta)
    );

endmodule

// ==== tb/gather_sys_sva.sv ====
`timescale 1ns/1ps

module gather_sys_sva (
    input logic                    clk,
    input logic                    srst,
    input logic                    desc_rdy,
    input logic                    pkt_vld,
    input logic                    pkt_rdy,
    input gather_types_pkg::word_t pkt_data,
    input logic                    pkt_eop,
    input gather_types_pkg::mty_t  pkt_mty,
    input gather_types_pkg::meta_t pkt_meta
);

    // A stalled beat keeps its contents
    a_hold_on_stall: assert property (@(posedge clk) disable iff (srst)
        (pkt_vld && !pkt_rdy) |=> (pkt_vld && $stable(pkt_data) && $stable(pkt_eop)
            && $stable(pkt_mty) && $stable(pkt_meta)))
        else $error("stalled output beat changed before it was taken");

    // Reset is synchronous, so outputs are checked from the second reset cycle on
    a_quiet_in_reset: assert property (@(posedge clk)
        (srst && $past(srst)) |-> (!pkt_vld && !desc_rdy))
        else $error("pkt_vld or desc_rdy high during reset");

    a_mty_only_on_eop: assert property (@(posedge clk) disable iff (srst)
        (pkt_vld && !pkt_eop) |-> (pkt_mty == '0))
        else $error("nonzero pkt_mty on a beat without eop");

endmodule

// ==== tb/gather_sys_tb.sv ====
`timescale 1ns/1ps
`include "gather_settings.svh"

module gather_sys_tb;

    localparam int MAX_ITEMS = 64;

    typedef struct packed {
        gather_types_pkg::meta_t meta;
        gather_types_pkg::word_t data;
        logic                    eop;
        gather_types_pkg::mty_t  mty;
    } beat_t;

    logic                          clk;
    logic                          srst;
    logic                          mem_wr;
    gather_types_pkg::mem_addr_t   mem_addr;
    gather_types_pkg::word_t       mem_data;
    logic                          link_wr;
    gather_types_pkg::buf_ptr_t    link_ptr;
    gather_types_pkg::buf_ptr_t    link_nxt;
    logic                          link_last;
    gather_types_pkg::buf_size_t   link_size;
    logic                          desc_vld;
    logic                          desc_rdy;
    gather_types_pkg::buf_ptr_t    desc_ptr;
    gather_types_pkg::meta_t       desc_meta;
    logic                          pkt_vld;
    logic                          pkt_rdy;
    gather_types_pkg::word_t       pkt_data;
    logic                          pkt_eop;
    gather_types_pkg::mty_t        pkt_mty;
    gather_types_pkg::meta_t       pkt_meta;

    // Trace contents
    gather_types_pkg::mem_addr_t   tr_mem_addr [MAX_ITEMS];
    gather_types_pkg::word_t       tr_mem_data [MAX_ITEMS];
    gather_types_pkg::buf_ptr_t    tr_link_ptr [MAX_ITEMS];
    gather_types_pkg::link_entry_t tr_link [MAX_ITEMS];
    gather_types_pkg::buf_ptr_t    tr_desc_ptr [MAX_ITEMS];
    gather_types_pkg::meta_t       tr_desc_meta [MAX_ITEMS];
    int                            tr_desc_test [MAX_ITEMS];
    beat_t                         tr_exp [MAX_ITEMS];
    int                            tr_exp_test [MAX_ITEMS];
    int                            n_mem;
    int                            n_link;
    int                            n_desc;
    int                            n_exp;
    logic                          trace_loaded;

    // Beats still owed by the running test
    beat_t                         exp_q [$];
    int                            beats_seen;
    logic                          in_pkt;
    gather_types_pkg::meta_t       open_meta;

    int                            errors;
    int                            tests_failed;
    integer                        seed;
    logic [31:0]                   rnd;
    logic                          rand_rdy;

    gather_sys dut (
        .clk       (clk),
        .srst      (srst),
        .mem_wr    (mem_wr),
        .mem_addr  (mem_addr),
        .mem_data  (mem_data),
        .link_wr   (link_wr),
        .link_ptr  (link_ptr),
        .link_nxt  (link_nxt),
        .link_last (link_last),
        .link_size (link_size),
        .desc_vld  (desc_vld),
        .desc_rdy  (desc_rdy),
        .desc_ptr  (desc_ptr),
        .desc_meta (desc_meta),
        .pkt_vld   (pkt_vld),
        .pkt_rdy   (pkt_rdy),
        .pkt_data  (pkt_data),
        .pkt_eop   (pkt_eop),
        .pkt_mty   (pkt_mty),
        .pkt_meta  (pkt_meta)
    );

    bind gather_sys gather_sys_sva u_sva (
        .clk      (clk),
        .srst     (srst),
        .desc_rdy (desc_rdy),
        .pkt_vld  (pkt_vld),
        .pkt_rdy  (pkt_rdy),
        .pkt_data (pkt_data),
        .pkt_eop  (pkt_eop),
        .pkt_mty  (pkt_mty),
        .pkt_meta (pkt_meta)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Output ready is random only while rand_rdy is set
    initial begin
        pkt_rdy = 1'b1;
        forever begin
            @(posedge clk);
            rnd = $random(seed);
            pkt_rdy <= rand_rdy ? rnd[0] : 1'b1;
        end
    end

    // --------------------
    // Trace reader
    // --------------------

    task automatic read_trace();
        int          fd;
        string       line;
        string       tag;
        int          cur_test;
        int          a;
        int          b;
        int          c;
        int          d;
        logic [63:0] w;
        fd = $fopen("tb/gather_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file tb/gather_trace.txt");
            errors++;
            return;
        end
        cur_test = 0;
        while ($fgets(line, fd) != 0) begin
            tag = "";
            void'($sscanf(line, "%s", tag));
            case (tag)
                "T": void'($sscanf(line, "%s %h", tag, cur_test));
                "M": begin
                    void'($sscanf(line, "%s %h %h", tag, a, w));
                    tr_mem_addr[n_mem] = gather_types_pkg::mem_addr_t'(a);
                    tr_mem_data[n_mem] = w;
                    n_mem++;
                end
                "L": begin
                    void'($sscanf(line, "%s %h %h %h %h", tag, a, b, c, d));
                    tr_link_ptr[n_link]  = gather_types_pkg::buf_ptr_t'(a);
                    tr_link[n_link].nxt  = gather_types_pkg::buf_ptr_t'(b);
                    tr_link[n_link].last = (c != 0);
                    tr_link[n_link].size = gather_types_pkg::buf_size_t'(d);
                    n_link++;
                end
                "D": begin
                    void'($sscanf(line, "%s %h %h", tag, a, b));
                    tr_desc_ptr[n_desc]  = gather_types_pkg::buf_ptr_t'(a);
                    tr_desc_meta[n_desc] = gather_types_pkg::meta_t'(b);
                    tr_desc_test[n_desc] = cur_test;
                    n_desc++;
                end
                "E": begin
                    void'($sscanf(line, "%s %h %h %h %h", tag, a, w, b, c));
                    tr_exp[n_exp].meta  = gather_types_pkg::meta_t'(a);
                    tr_exp[n_exp].data  = w;
                    tr_exp[n_exp].eop   = (b != 0);
                    tr_exp[n_exp].mty   = gather_types_pkg::mty_t'(c);
                    tr_exp_test[n_exp]  = cur_test;
                    n_exp++;
                end
                default: ;
            endcase
        end
        $fclose(fd);
    endtask

    // --------------------
    // Stimulus
    // --------------------

    task automatic write_tables();
        int i;
        for (i = 0; i < n_mem; i++) begin
            mem_wr   <= 1'b1;
            mem_addr <= tr_mem_addr[i];
            mem_data <= tr_mem_data[i];
            @(posedge clk);
        end
        mem_wr <= 1'b0;
        for (i = 0; i < n_link; i++) begin
            link_wr   <= 1'b1;
            link_ptr  <= tr_link_ptr[i];
            link_nxt  <= tr_link[i].nxt;
            link_last <= tr_link[i].last;
            link_size <= tr_link[i].size;
            @(posedge clk);
        end
        link_wr <= 1'b0;
        @(posedge clk);
    endtask

    // Holds the descriptor until the edge that transfers it
    task automatic send_desc(input int k, output int waits);
        waits     = 0;
        desc_vld  <= 1'b1;
        desc_ptr  <= tr_desc_ptr[k];
        desc_meta <= tr_desc_meta[k];
        @(posedge clk);
        while (!desc_rdy) begin
            waits++;
            @(posedge clk);
        end
    endtask

    // --------------------
    // Checking
    // --------------------

    task automatic check_beat();
        int    i;
        int    idx;
        beat_t want;
        idx = -1;
        for (i = exp_q.size() - 1; i >= 0; i--) begin
            if (exp_q[i].meta == pkt_meta) idx = i;
        end
        if (in_pkt) begin
            assert (pkt_meta == open_meta) else begin
                $display("CHECK FAILED pkt_meta expected %h actual %h", open_meta, pkt_meta);
                errors++;
            end
        end
        in_pkt    = !pkt_eop;
        open_meta = pkt_meta;
        beats_seen++;
        assert (idx >= 0) else begin
            $display("A beat with meta %h arrived, but none was expected", pkt_meta);
            errors++;
        end
        if (idx >= 0) begin
            want = exp_q[idx];
            exp_q.delete(idx);
            assert (pkt_data == want.data) else begin
                $display("CHECK FAILED pkt_data expected %h actual %h", want.data, pkt_data);
                errors++;
            end
            assert (pkt_eop == want.eop) else begin
                $display("CHECK FAILED pkt_eop expected %h actual %h", want.eop, pkt_eop);
                errors++;
            end
            assert (pkt_mty == want.mty) else begin
                $display("CHECK FAILED pkt_mty expected %h actual %h", want.mty, pkt_mty);
                errors++;
            end
        end
    endtask

    initial begin
        forever begin
            @(posedge clk);
            if (!srst && pkt_vld && pkt_rdy) begin
                check_beat();
            end
        end
    end

    task automatic report_test(input int num, input string name, input int err0);
        if (errors == err0) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            $display("test %0d %s: fail with %0d errors", num, name, errors - err0);
            tests_failed++;
        end
    endtask

    task automatic check_reset_state();
        int   err0;
        logic seen_rdy;
        err0     = errors;
        seen_rdy = 1'b0;
        repeat (8) begin
            @(posedge clk);
            assert (pkt_vld == 1'b0) else begin
                $display("CHECK FAILED pkt_vld expected %h actual %h", 1'b0, pkt_vld);
                errors++;
            end
            if (desc_rdy) seen_rdy = 1'b1;
        end
        assert (seen_rdy) else begin
            $display("desc_rdy did not rise after reset was released");
            errors++;
        end
        report_test(1, "reset state", err0);
    endtask

    task automatic run_test(input int num, input string name);
        int err0;
        int n_beats;
        int n_sent;
        int waits;
        int k;
        err0       = errors;
        n_beats    = 0;
        n_sent     = 0;
        beats_seen = 0;
        for (k = 0; k < n_exp; k++) begin
            if (tr_exp_test[k] == num) begin
                exp_q.push_back(tr_exp[k]);
                n_beats++;
            end
        end
        rand_rdy <= (num == 3);
        for (k = 0; k < n_desc; k++) begin
            if (tr_desc_test[k] == num) begin
                send_desc(k, waits);
                // Both lanes start idle, so the second descriptor goes to the other lane at once
                if (num == 4 && n_sent == 1) begin
                    assert (waits == 0) else begin
                        $display("CHECK FAILED desc_rdy expected %h actual %h", 1'b1, 1'b0);
                        errors++;
                    end
                end
                n_sent++;
            end
        end
        desc_vld <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // Window for any trailing beat
        repeat (20) @(posedge clk);
        rand_rdy <= 1'b0;
        assert (beats_seen == n_beats) else begin
            $display("CHECK FAILED beat_count expected %h actual %h", n_beats, beats_seen);
            errors++;
        end
        report_test(num, name, err0);
    endtask

    // Watchdog sized from the descriptor count
    initial begin
        wait (trace_loaded);
        repeat (200 * n_desc + 1000) @(posedge clk);
        $display("Timeout, the run did not finish within %0d cycles", 200 * n_desc + 1000);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        srst         = 1'b1;
        mem_wr       = 1'b0;
        mem_addr     = '0;
        mem_data     = '0;
        link_wr      = 1'b0;
        link_ptr     = '0;
        link_nxt     = '0;
        link_last    = 1'b0;
        link_size    = '0;
        desc_vld     = 1'b0;
        desc_ptr     = '0;
        desc_meta    = '0;
        rand_rdy     = 1'b0;
        seed         = 32'h334e_2213;
        errors       = 0;
        tests_failed = 0;
        n_mem        = 0;
        n_link       = 0;
        n_desc       = 0;
        n_exp        = 0;
        beats_seen   = 0;
        in_pkt       = 1'b0;
        open_meta    = '0;
        trace_loaded = 1'b0;
        read_trace();
        trace_loaded = 1'b1;
        repeat (4) @(posedge clk);
        srst <= 1'b0;
        check_reset_state();
        write_tables();
        run_test(2, "single buffer with partial last word");
        run_test(3, "three chained buffers with random ready");
        run_test(4, "back-to-back descriptors over both lanes");
        run_test(5, "full last buffer");
        $display("tests run 5, tests failed %0d, check errors %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/gather_trace.txt ====
# M addr data | L ptr nxt last size | D ptr meta | E meta data eop mty
# T n starts test n, all numbers in hex
M 04 a504c3045a043c04
M 05 a505c3055a053c05
M 08 a508c3085a083c08
M 09 a509c3095a093c09
M 0a a50ac30a5a0a3c0a
M 0b a50bc30b5a0b3c0b
M 0c a50cc30c5a0c3c0c
M 0d a50dc30d5a0d3c0d
M 0e a50ec30e5a0e3c0e
M 0f a50fc30f5a0f3c0f
M 14 a514c3145a143c14
M 18 a518c3185a183c18
M 19 a519c3195a193c19
M 1a a51ac31a5a1a3c1a
M 1b a51bc31b5a1b3c1b
L 1 0 1 0d
L 2 3 0 20
L 3 5 0 20
L 5 0 1 06
L 6 0 1 20
T 2
D 1 21
E 21 a504c3045a043c04 0 0
E 21 a505c3055a053c05 1 3
T 3
D 2 31
E 31 a508c3085a083c08 0 0
E 31 a509c3095a093c09 0 0
E 31 a50ac30a5a0a3c0a 0 0
E 31 a50bc30b5a0b3c0b 0 0
E 31 a50cc30c5a0c3c0c 0 0
E 31 a50dc30d5a0d3c0d 0 0
E 31 a50ec30e5a0e3c0e 0 0
E 31 a50fc30f5a0f3c0f 0 0
E 31 a514c3145a143c14 1 2
T 4
D 1 41
D 6 42
D 1 43
E 41 a504c3045a043c04 0 0
E 41 a505c3055a053c05 1 3
E 42 a518c3185a183c18 0 0
E 42 a519c3195a193c19 0 0
E 42 a51ac31a5a1a3c1a 0 0
E 42 a51bc31b5a1b3c1b 1 0
E 43 a504c3045a043c04 0 0
E 43 a505c3055a053c05 1 3
T 5
D 6 51
E 51 a518c3185a183c18 0 0
E 51 a519c3195a193c19 0 0
E 51 a51ac31a5a1a3c1a 0 0
E 51 a51bc31b5a1b3c1b 1 0

// ==== gather_sys.f ====
+incdir+.
hdl/gather_types_pkg.sv
hdl/gather_ctrl_pkg.sv
hdl/gather_intf.sv
hdl/desc_dispatch.sv
hdl/gather_lane.sv
hdl/pkt_arbiter.sv
hdl/gather_sys.sv
tb/gather_sys_sva.sv
tb/gather_sys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module gather_sys_tb \
        -f gather_sys.f -o gather_sim \
    && ./obj_dir/gather_sim | tee /dev/stderr | grep -x "Result: PASSED" > /dev/null \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }
